// File: rtl/vpair_config.svh
`ifndef VPAIR_CONFIG_SVH
`define VPAIR_CONFIG_SVH

// ==============================
// video widths
// ==============================

`define VPAIR_COLOR_W       8                       // bits per channel
`define VPAIR_RGB_W         (3 * `VPAIR_COLOR_W)    // r, g, b packed msb first

// ==============================
// pair buffer
// ==============================

`define VPAIR_FIFO_DEPTH    16                      // words, one pair each

// ==============================
// osd palette, indexed by code 0..3
// ==============================

`define VPAIR_OSD_BLACK     24'h000000
`define VPAIR_OSD_BLUE      24'h0000ff
`define VPAIR_OSD_YELLOW    24'hffff00
`define VPAIR_OSD_WHITE     24'hffffff

`endif

// File: rtl/vpair_pkg.sv
`default_nettype none

`include "vpair_config.svh"

package vpair_pkg;

    // ==============================
    // pixel types
    // ==============================

    // one pixel inside the path, syncs carried as active-high flags
    typedef struct packed {
        logic [`VPAIR_RGB_W-1:0] rgb;   // {r, g, b}
        logic                    hs;    // hsync asserted
        logic                    vs;    // vsync asserted
        logic                    de;    // active video
    } pixel_t;

    // two pixels per buffer word
    // first pixel in time sits in the upper half
    typedef struct packed {
        pixel_t first;
        pixel_t second;
    } pixel_pair_t;

    // ==============================
    // osd
    // ==============================

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_t;

endpackage

`default_nettype wire

// File: rtl/pixel_pair_packer.sv
`default_nettype none

`include "vpair_config.svh"

module pixel_pair_packer (
    input  wire                     clk27,
    input  wire                     sys_reset_n,
    input  wire                     vid_valid_i,
    input  wire [`VPAIR_RGB_W-1:0]  vid_rgb_i,
    input  wire                     vid_hsync_i,
    input  wire                     vid_vsync_i,
    input  wire                     vid_de_i,
    input  wire                     hsync_pol_i,    // 1 = active high
    input  wire                     vsync_pol_i,    // 1 = active high
    input  wire                     full_i,
    output logic                    pair_wr_o,
    output vpair_pkg::pixel_pair_t  pair_o
);
    import vpair_pkg::*;

    pixel_t     pix_in;         // incoming pixel, syncs normalized
    pixel_t     first_pix;      // upper half waiting for its partner
    logic       have_first;
    logic       vs_prev;        // normalized vs of the last valid pixel
    logic       vs_rise;
    logic       start_pair;     // this pixel opens a new pair
    logic [7:0] lost_pairs;

    // ==============================
    // sync normalization
    // ==============================

    always_comb begin
        pix_in.rgb = vid_rgb_i;
        pix_in.hs  = vid_hsync_i ~^ hsync_pol_i;    // invert when active low
        pix_in.vs  = vid_vsync_i ~^ vsync_pol_i;
        pix_in.de  = vid_de_i;
    end

    assign vs_rise    = pix_in.vs & ~vs_prev;
    // frame start drops any half pair and realigns
    assign start_pair = vs_rise | ~have_first;

    // ==============================
    // pair assembly
    // ==============================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            have_first <= 1'b0;
            vs_prev    <= 1'b0;
            pair_wr_o  <= 1'b0;
        end else begin
            pair_wr_o <= 1'b0;
            if (vid_valid_i) begin
                vs_prev <= pix_in.vs;
                if (start_pair) begin
                    have_first <= 1'b1;
                end else begin
                    have_first <= 1'b0;
                    pair_wr_o  <= 1'b1;     // second pixel in, write next cycle
                end
            end
        end
    end

    always_ff @(posedge clk27) begin
        if (vid_valid_i) begin
            if (start_pair) begin
                first_pix <= pix_in;
            end else begin
                pair_o.first  <= first_pix;
                pair_o.second <= pix_in;
            end
        end
    end

    // pairs offered into a full buffer
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            lost_pairs <= '0;
        end else if (pair_wr_o && full_i && (lost_pairs != '1)) begin
            lost_pairs <= lost_pairs + 1'b1;    // saturates
        end
    end

    // the consumer drains as fast as pixels arrive, so the buffer never fills
    a_no_wr_full : assert property (@(posedge clk27) disable iff (!sys_reset_n)
        pair_wr_o |-> !full_i)
        else $error("pixel pair lost on full buffer, %0d so far", lost_pairs + 8'd1);

endmodule

`default_nettype wire

// File: rtl/pair_fifo.sv
`default_nettype none

`include "vpair_config.svh"

module pair_fifo (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    input  wire                          wr_i,
    input  wire vpair_pkg::pixel_pair_t  wr_data_i,
    input  wire                          rd_i,
    output vpair_pkg::pixel_pair_t       rd_data_o,
    output logic                         full_o,
    output logic                         empty_o
);
    import vpair_pkg::*;

    localparam int DEPTH = `VPAIR_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    pixel_pair_t     mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;     // words held
    logic            wr_en;
    logic            rd_en;

    assign full_o  = (count == CW'(DEPTH));
    assign empty_o = (count == '0);
    assign wr_en   = wr_i & ~full_o;
    assign rd_en   = rd_i & ~empty_o;

    // ==============================
    // storage
    // ==============================

    always_ff @(posedge clk27) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (rd_en) begin
            rd_data_o <= mem[rd_ptr];   // valid the cycle after rd_i
        end
    end

    // ==============================
    // pointers and occupancy
    // ==============================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none or both
            endcase
        end
    end

    // ==============================
    // checks
    // ==============================

    a_wr_full : assert property (@(posedge clk27) disable iff (!sys_reset_n)
        wr_i |-> !full_o)
        else $error("write into full pair buffer");

    // reader is expected to look at empty_o before asking
    a_rd_empty : assert property (@(posedge clk27) disable iff (!sys_reset_n)
        rd_i |-> !empty_o)
        else $error("read from empty pair buffer");

    a_count_max : assert property (@(posedge clk27) disable iff (!sys_reset_n)
        count <= CW'(DEPTH))
        else $error("pair buffer count past depth");

endmodule

`default_nettype wire

// File: rtl/pixel_pair_unpacker.sv
`default_nettype none

`include "vpair_config.svh"

module pixel_pair_unpacker (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    input  wire                          empty_i,
    input  wire vpair_pkg::pixel_pair_t  rd_data_i,
    output logic                         rd_o,
    input  wire                          osd_enable_i,
    input  wire vpair_pkg::osd_color_t   osd_color_i,
    output logic                         out_valid_o,
    output logic [`VPAIR_RGB_W-1:0]      out_rgb_o,
    output logic                         out_hsync_o,   // active low
    output logic                         out_vsync_o,   // active low
    output logic                         out_de_o,
    output logic                         frame_start_o
);
    import vpair_pkg::*;

    logic                     rd_pending;   // pair lands on rd_data_i this cycle
    logic                     lower_valid;  // second pixel goes out this cycle
    pixel_t                   lower_pix;
    pixel_t                   cur_pix;
    logic                     emit;
    logic [`VPAIR_RGB_W-1:0]  osd_rgb;
    logic                     vsync_prev;

    // next read may overlap the lower pixel going out
    assign rd_o = ~empty_i & ~rd_pending;

    assign emit    = rd_pending | lower_valid;
    assign cur_pix = rd_pending ? rd_data_i.first : lower_pix;

    // ==============================
    // osd colour lookup
    // ==============================

    always_comb begin
        case (osd_color_i)
            OSD_BLACK:  osd_rgb = `VPAIR_OSD_BLACK;
            OSD_BLUE:   osd_rgb = `VPAIR_OSD_BLUE;
            OSD_YELLOW: osd_rgb = `VPAIR_OSD_YELLOW;
            OSD_WHITE:  osd_rgb = `VPAIR_OSD_WHITE;
            default:    osd_rgb = `VPAIR_OSD_BLACK;
        endcase
    end

    // ==============================
    // output stage
    // ==============================

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            rd_pending    <= 1'b0;
            lower_valid   <= 1'b0;
            out_valid_o   <= 1'b0;
            out_de_o      <= 1'b0;
            out_hsync_o   <= 1'b1;
            out_vsync_o   <= 1'b1;
            vsync_prev    <= 1'b1;
            frame_start_o <= 1'b0;
        end else begin
            rd_pending  <= rd_o;
            lower_valid <= rd_pending;
            out_valid_o <= emit;
            out_de_o    <= emit & cur_pix.de;   // de low in gaps
            if (emit) begin
                // syncs hold between pairs
                out_hsync_o <= ~cur_pix.hs;
                out_vsync_o <= ~cur_pix.vs;
            end
            vsync_prev    <= out_vsync_o;
            // falling edge of the emitted vsync
            frame_start_o <= out_valid_o & vsync_prev & ~out_vsync_o;
        end
    end

    always_ff @(posedge clk27) begin
        if (rd_pending) begin
            lower_pix <= rd_data_i.second;
        end
        if (emit) begin
            out_rgb_o <= osd_enable_i ? osd_rgb : cur_pix.rgb;
        end
    end

    // each read gives exactly two output cycles, two and three cycles later
    a_two_per_read : assert property (@(posedge clk27) disable iff (!sys_reset_n)
        out_valid_o |-> ($past(rd_o, 2) || $past(rd_o, 3)))
        else $error("output pixel without a matching pair read");

endmodule

`default_nettype wire

// File: rtl/video_pair_path.sv
`default_nettype none

`include "vpair_config.svh"

module video_pair_path (
    input  wire                          clk27,
    input  wire                          sys_reset_n,
    // digitizer side
    input  wire                          vid_valid_i,
    input  wire [`VPAIR_RGB_W-1:0]       vid_rgb_i,
    input  wire                          vid_hsync_i,
    input  wire                          vid_vsync_i,
    input  wire                          vid_de_i,
    input  wire                          hsync_pol_i,
    input  wire                          vsync_pol_i,
    // osd
    input  wire                          osd_enable_i,
    input  wire vpair_pkg::osd_color_t   osd_color_i,
    // hdmi side
    output wire                          out_valid_o,
    output wire [`VPAIR_RGB_W-1:0]       out_rgb_o,
    output wire                          out_hsync_o,
    output wire                          out_vsync_o,
    output wire                          out_de_o,
    output wire                          frame_start_o
);

    wire                          pair_wr;
    wire vpair_pkg::pixel_pair_t  pair_wr_data;
    wire                          fifo_full;
    wire                          fifo_empty;
    wire                          pair_rd;
    wire vpair_pkg::pixel_pair_t  pair_rd_data;

    pixel_pair_packer u_packer (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .vid_valid_i (vid_valid_i),
        .vid_rgb_i   (vid_rgb_i),
        .vid_hsync_i (vid_hsync_i),
        .vid_vsync_i (vid_vsync_i),
        .vid_de_i    (vid_de_i),
        .hsync_pol_i (hsync_pol_i),
        .vsync_pol_i (vsync_pol_i),
        .full_i      (fifo_full),
        .pair_wr_o   (pair_wr),
        .pair_o      (pair_wr_data)
    );

    pair_fifo u_fifo (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .wr_i        (pair_wr),
        .wr_data_i   (pair_wr_data),
        .rd_i        (pair_rd),
        .rd_data_o   (pair_rd_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    pixel_pair_unpacker u_unpacker (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .empty_i       (fifo_empty),
        .rd_data_i     (pair_rd_data),
        .rd_o          (pair_rd),
        .osd_enable_i  (osd_enable_i),
        .osd_color_i   (osd_color_i),
        .out_valid_o   (out_valid_o),
        .out_rgb_o     (out_rgb_o),
        .out_hsync_o   (out_hsync_o),
        .out_vsync_o   (out_vsync_o),
        .out_de_o      (out_de_o),
        .frame_start_o (frame_start_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 4;     // 8 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: tb/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// ==============================
// directed tests
// ==============================

task automatic reset_state_test();
    begin_test("reset_state");
    idle_cycles(1);
    compare_value("out_valid_o", 32'd0, 32'(out_valid_o));
    compare_value("out_de_o", 32'd0, 32'(out_de_o));
    compare_value("frame_start_o", 32'd0, 32'(frame_start_o));
    compare_value("out_hsync_o", 32'd1, 32'(out_hsync_o));   // inactive
    compare_value("out_vsync_o", 32'd1, 32'(out_vsync_o));
    end_test(0);
endtask

// vsync stays idle so no realignment happens
task automatic order_content_test();
    int          n;
    logic [31:0] r;
    begin_test("order_content");
    for (n = 0; n < 16; n++) begin
        r = next_random();
        send_pixel(r[`VPAIR_RGB_W-1:0], r[31], 1'b0, 1'b1, 1'b1);   // back to back
    end
    idle_cycles(1);
    for (n = 0; n < 20; n++) begin
        r = next_random();
        send_pixel(r[`VPAIR_RGB_W-1:0], r[31], 1'b0, 1'b1, 1'b1);
        idle_cycles(int'(r[30:29]));    // 0 to 3 idle cycles
    end
    wait_drained();
    end_test(0);
endtask

task automatic polarity_test();
    int          n;
    logic [31:0] r;
    begin_test("polarity");
    set_controls(1'b0, 1'b0, 1'b0, OSD_BLACK);
    for (n = 0; n < 12; n++) begin
        r = next_random();
        // active-low syncs in, vsync high means idle
        send_pixel(r[`VPAIR_RGB_W-1:0], r[31], 1'b1, 1'b1, 1'b1);
    end
    wait_drained();
    set_controls(1'b1, 1'b1, 1'b0, OSD_BLACK);
    end_test(0);
endtask

task automatic osd_overlay_test();
    int          c;
    int          n;
    logic [31:0] r;
    begin_test("osd_overlay");
    for (c = 0; c < 4; c++) begin
        set_controls(1'b1, 1'b1, 1'b1, osd_color_t'(c));
        for (n = 0; n < 6; n++) begin
            r = next_random();
            send_pixel(r[`VPAIR_RGB_W-1:0], r[31], 1'b0, r[30], 1'b1);   // random de
        end
        wait_drained();
    end
    set_controls(1'b1, 1'b1, 1'b0, OSD_BLACK);
    end_test(0);
endtask

task automatic frame_realign_test();
    int          n;
    logic [31:0] r;
    begin_test("frame_realign");
    // fifth pixel is left without a partner
    for (n = 0; n < 5; n++) begin
        r = next_random();
        send_pixel(r[`VPAIR_RGB_W-1:0], 1'b0, 1'b0, 1'b1, n < 4);
    end
    // new frame, vsync over three blank pixels
    for (n = 0; n < 6; n++) begin
        r = next_random();
        send_pixel(r[`VPAIR_RGB_W-1:0], 1'b0, n < 3, n >= 3, 1'b1);
    end
    wait_drained();
    end_test(1);
endtask

`endif

// File: tb/tb_video_pair_path.sv
`default_nettype none

`include "vpair_config.svh"

module tb_video_pair_path;
    timeunit 1ns;
    timeprecision 100ps;

    import vpair_pkg::*;

    localparam int PIX_W    = `VPAIR_RGB_W + 3;    // {rgb, hsync, vsync, de} at the output
    localparam int WAIT_MAX = 100;                 // cycles a drain may take

    logic                     clk27;
    logic                     sys_reset_n;
    logic                     vid_valid_i;
    logic [`VPAIR_RGB_W-1:0]  vid_rgb_i;
    logic                     vid_hsync_i;
    logic                     vid_vsync_i;
    logic                     vid_de_i;
    logic                     hsync_pol_i;
    logic                     vsync_pol_i;
    logic                     osd_enable_i;
    osd_color_t               osd_color_i;
    wire                      out_valid_o;
    wire  [`VPAIR_RGB_W-1:0]  out_rgb_o;
    wire                      out_hsync_o;
    wire                      out_vsync_o;
    wire                      out_de_o;
    wire                      frame_start_o;

    logic [PIX_W-1:0]  exp_q [$];  // pixels still to come out, in order
    logic [31:0]       rng_state;
    string             cur_test;
    int                errors;
    int                checks;
    int                tests_run;
    int                test_err_start;
    int                frame_pulses;
    int                pulse_start;
    logic              last_hs;    // expected syncs of the last emitted pixel
    logic              last_vs;
    logic              fs_due;     // frame start expected at the next sample

    tb_clock_gen u_clk (
        .clk_o (clk27)
    );

    video_pair_path DUT (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .vid_valid_i   (vid_valid_i),
        .vid_rgb_i     (vid_rgb_i),
        .vid_hsync_i   (vid_hsync_i),
        .vid_vsync_i   (vid_vsync_i),
        .vid_de_i      (vid_de_i),
        .hsync_pol_i   (hsync_pol_i),
        .vsync_pol_i   (vsync_pol_i),
        .osd_enable_i  (osd_enable_i),
        .osd_color_i   (osd_color_i),
        .out_valid_o   (out_valid_o),
        .out_rgb_o     (out_rgb_o),
        .out_hsync_o   (out_hsync_o),
        .out_vsync_o   (out_vsync_o),
        .out_de_o      (out_de_o),
        .frame_start_o (frame_start_o)
    );

    // ==============================
    // reference and random helpers
    // ==============================

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [`VPAIR_RGB_W-1:0] osd_value(input logic [1:0] code);
        case (code)
            2'd0: return `VPAIR_OSD_BLACK;
            2'd1: return `VPAIR_OSD_BLUE;
            2'd2: return `VPAIR_OSD_YELLOW;
            2'd3: return `VPAIR_OSD_WHITE;
        endcase
    endfunction

    function automatic logic [PIX_W-1:0] expected_pixel(input logic [`VPAIR_RGB_W-1:0] rgb,
            input logic hs, input logic vs, input logic de);
        logic                     hs_on;
        logic                     vs_on;
        logic [`VPAIR_RGB_W-1:0]  color;
        hs_on = hsync_pol_i ? hs : ~hs;     // sync asserted at the input
        vs_on = vsync_pol_i ? vs : ~vs;
        color = osd_enable_i ? osd_value(osd_color_i) : rgb;
        return {color, ~hs_on, ~vs_on, de};     // output syncs active low
    endfunction

    // ==============================
    // checks and per-cycle sampling
    // ==============================

    task automatic compare_value(input string what, input logic [31:0] want,
                                 input logic [31:0] got);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, want, got);
        end
    endtask

    task automatic expect_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s: %s", cur_test, msg);
        end
    endtask

    task automatic sample_outputs();
        logic [PIX_W-1:0] got;
        logic [PIX_W-1:0] want;
        got = {out_rgb_o, out_hsync_o, out_vsync_o, out_de_o};
        compare_value("frame_start_o", 32'(fs_due), 32'(frame_start_o));
        if (frame_start_o) begin
            frame_pulses++;
        end
        fs_due = 1'b0;
        if (out_valid_o) begin
            expect_true(exp_q.size() != 0, "an output pixel came out with none expected");
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                compare_value("pixel", 32'(want), 32'(got));
                fs_due  = last_vs & ~want[1];   // vsync falls on this pixel
                last_hs = want[2];
                last_vs = want[1];
            end
        end else begin
            // gap between pairs
            compare_value("gap de", 32'd0, 32'(out_de_o));
            compare_value("gap hsync", 32'(last_hs), 32'(out_hsync_o));
            compare_value("gap vsync", 32'(last_vs), 32'(out_vsync_o));
        end
    endtask

    // ==============================
    // drive helpers
    // ==============================

    task automatic step_cycle(input logic valid, input logic [`VPAIR_RGB_W-1:0] rgb,
                              input logic hs, input logic vs, input logic de);
        @(posedge clk27);
        vid_valid_i <= valid;
        vid_rgb_i   <= rgb;
        vid_hsync_i <= hs;
        vid_vsync_i <= vs;
        vid_de_i    <= de;
        @(negedge clk27);
        sample_outputs();
    endtask

    task automatic send_pixel(input logic [`VPAIR_RGB_W-1:0] rgb, input logic hs,
                              input logic vs, input logic de, input logic expect_out);
        if (expect_out) begin
            exp_q.push_back(expected_pixel(rgb, hs, vs, de));
        end
        step_cycle(1'b1, rgb, hs, vs, de);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            step_cycle(1'b0, '0, vid_hsync_i, vid_vsync_i, 1'b0);   // syncs held
        end
    endtask

    task automatic set_controls(input logic hpol, input logic vpol, input logic osd_en,
                                input osd_color_t code);
        @(posedge clk27);
        vid_valid_i  <= 1'b0;
        hsync_pol_i  <= hpol;
        vsync_pol_i  <= vpol;
        osd_enable_i <= osd_en;
        osd_color_i  <= code;
        @(negedge clk27);
        sample_outputs();
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_MAX) begin
            idle_cycles(1);
            waited++;
        end
        expect_true(exp_q.size() == 0,
                    $sformatf("timed out, %0d expected pixels never came out", exp_q.size()));
        exp_q.delete();
        idle_cycles(2);     // frame start lands one cycle after its pixel
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
        pulse_start    = frame_pulses;
        tests_run++;
    endtask

    task automatic end_test(input int exp_pulses);
        compare_value("frame start count", 32'(exp_pulses), 32'(frame_pulses - pulse_start));
        if (errors == test_err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d error(s)", cur_test, errors - test_err_start);
        end
    endtask

    `include "tb_tests.svh"

    // ==============================
    // main sequence
    // ==============================

    initial begin
        sys_reset_n    = 1'b0;
        vid_valid_i    = 1'b0;
        vid_rgb_i      = '0;
        vid_hsync_i    = 1'b0;
        vid_vsync_i    = 1'b0;
        vid_de_i       = 1'b0;
        hsync_pol_i    = 1'b1;
        vsync_pol_i    = 1'b1;
        osd_enable_i   = 1'b0;
        osd_color_i    = OSD_BLACK;
        rng_state      = 32'd83614;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        test_err_start = 0;
        frame_pulses   = 0;
        pulse_start    = 0;
        last_hs        = 1'b1;
        last_vs        = 1'b1;
        fs_due         = 1'b0;

        repeat (4) @(posedge clk27);
        sys_reset_n <= 1'b1;

        reset_state_test();
        order_content_test();
        polarity_test();
        osd_overlay_test();
        frame_realign_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_video_pair_path
RTL_TOP    = video_pair_path
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
SIM_BIN    = ./$(OBJ_DIR)/V$(TOP)
LOG        = sim.log
FAIL_MSG   = ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# an aborted simulation counts as a failure
run: build
	$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: vlog.f
+incdir+rtl
+incdir+tb
rtl/vpair_pkg.sv
rtl/pixel_pair_packer.sv
rtl/pair_fifo.sv
rtl/pixel_pair_unpacker.sv
rtl/video_pair_path.sv
tb/tb_clock_gen.sv
tb/tb_video_pair_path.sv
